// ==== Bender.yml ====
package:
  name: bt_stream_link

sources:
  - logic/link_frame_pkg.sv
  - logic/uart_timing_pkg.sv
  - logic/stream_fifo_bank.sv
  - logic/stream_switch.sv
  - logic/packet_sequencer.sv
  - logic/uart_tx.sv
  - logic/bt_stream_link.sv
  - target: simulation
    files:
      - verification/bt_stream_link_tb.sv

// ==== logic/bt_stream_link.sv ====
// Top level of the datastream link with queues, switch, sequencer and UART
`timescale 1ns/1ps
`default_nettype none

module bt_stream_link (
	input logic clock,
	input logic reset,
	input link_frame_pkg::channel_mask_t frame_ready_i,
	input link_frame_pkg::payload_t payload_i [link_frame_pkg::N_CHANNELS],
	input link_frame_pkg::channel_mask_t stream_mask_i,
	input logic send_enable_i,
	input uart_timing_pkg::uart_cfg_t uart_cfg_i,
	output logic txd_o,
	output logic busy_o
);
	import link_frame_pkg::*;

	frame_t frame;
	channel_mask_t empty;
	channel_id_t select;
	logic select_ready;
	logic advance;
	logic pop;
	logic tx_start;
	logic tx_done;
	logic [7:0] tx_byte;

	stream_fifo_bank u_fifo_bank (
		.clock(clock),
		.reset(reset),
		.frame_ready_i(frame_ready_i),
		.payload_i(payload_i),
		.pop_i(pop),
		.select_i(select),
		.frame_o(frame),
		.empty_o(empty)
	);

	stream_switch u_switch (
		.clock(clock),
		.reset(reset),
		.advance_i(advance),
		.mask_i(stream_mask_i),
		.empty_i(empty),
		.select_o(select),
		.select_ready_o(select_ready)
	);

	packet_sequencer u_sequencer (
		.clock(clock),
		.reset(reset),
		.send_enable_i(send_enable_i),
		.mask_i(stream_mask_i),
		.empty_i(empty),
		.select_ready_i(select_ready),
		.frame_i(frame),
		.uart_cfg_i(uart_cfg_i),
		.tx_done_i(tx_done),
		.advance_o(advance),
		.pop_o(pop),
		.tx_start_o(tx_start),
		.tx_byte_o(tx_byte),
		.busy_o(busy_o)
	);

	uart_tx u_uart_tx (
		.clock(clock),
		.reset(reset),
		.start_i(tx_start),
		.data_i(tx_byte),
		.cycles_per_bit_i(uart_cfg_i.cycles_per_bit),
		.txd_o(txd_o),
		.tx_done_o(tx_done)
	);

endmodule

`default_nettype wire

// ==== logic/link_frame_pkg.sv ====
// Channel count, frame layout, queue sizing and packet byte types
`default_nettype none

package link_frame_pkg;

	// Sensor channels
	localparam int N_CHANNELS = 8;

	typedef logic [$clog2(N_CHANNELS)-1:0] channel_id_t;
	typedef logic [N_CHANNELS-1:0] channel_mask_t;

	// One measurement from a sensor
	localparam int PAYLOAD_BITS = 110;

	typedef logic [PAYLOAD_BITS-1:0] payload_t;

	// Most significant byte goes out first
	typedef struct packed {
		logic [7:0] trailer_id;
		logic [1:0] pad;
		payload_t payload;
		logic [7:0] header_id;
	} frame_t;

	// Serial packet view of a frame
	localparam int PACKET_BYTES = 16;

	typedef logic [$clog2(PACKET_BYTES)-1:0] byte_index_t;
	typedef logic [PACKET_BYTES-1:0][7:0] packet_t;

	localparam byte_index_t LAST_BYTE = byte_index_t'(PACKET_BYTES - 1);

	// Per channel queue
	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH);

	typedef logic [FIFO_PTR_BITS-1:0] fifo_ptr_t;
	typedef logic [FIFO_PTR_BITS:0] fifo_count_t;

endpackage

`default_nettype wire

// ==== logic/packet_sequencer.sv ====
// Send FSM with packet byte buffer, byte index and byte and packet spacing timers
`timescale 1ns/1ps
`default_nettype none

module packet_sequencer (
	input logic clock,
	input logic reset,
	input logic send_enable_i,
	input link_frame_pkg::channel_mask_t mask_i,
	input link_frame_pkg::channel_mask_t empty_i,
	input logic select_ready_i,
	input link_frame_pkg::frame_t frame_i,
	input uart_timing_pkg::uart_cfg_t uart_cfg_i,
	input logic tx_done_i,
	output logic advance_o,
	output logic pop_o,
	output logic tx_start_o,
	output logic [7:0] tx_byte_o,
	output logic busy_o
);
	import link_frame_pkg::*;
	import uart_timing_pkg::*;

	typedef enum logic [2:0] {
		idle,
		wait_for_clearance,
		release_from_fifo,
		load_buffer,
		rest_byte,
		send_byte,
		rest_transmission
	} state_t;

	state_t state;
	packet_t buffer;
	byte_index_t byte_index;
	cycle_count_t byte_timer;
	packet_gap_count_t packet_timer;
	logic data_left;
	logic send_ok;
	logic packet_sent;
	logic byte_gap_done;
	logic packet_gap_done;

	// Some requested channel still has a frame waiting
	assign data_left = |(mask_i & ~empty_i);
	assign send_ok = send_enable_i & data_left;

	assign packet_sent = (byte_index == LAST_BYTE);
	assign byte_gap_done = (byte_timer == uart_cfg_i.byte_gap);
	assign packet_gap_done = (packet_timer == packet_gap_count_t'(PACKET_GAP));

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			state <= idle;
			byte_index <= '0;
			byte_timer <= '0;
			packet_timer <= '0;
			advance_o <= 1'b0;
			pop_o <= 1'b0;
			tx_start_o <= 1'b0;
		end
		else
		begin
			// Strobes last a single cycle
			advance_o <= 1'b0;
			pop_o <= 1'b0;
			tx_start_o <= 1'b0;
			case (state)
				idle:
				begin
					if (send_ok)
					begin
						state <= wait_for_clearance;
						advance_o <= 1'b1;
					end
				end
				wait_for_clearance:
				begin
					if (!send_ok)
						state <= idle;
					else if (select_ready_i)
					begin
						state <= release_from_fifo;
						pop_o <= 1'b1;
					end
				end
				release_from_fifo:
				begin
					state <= load_buffer;
				end
				load_buffer:
				begin
					byte_index <= '0;
					state <= rest_byte;
				end
				rest_byte:
				begin
					state <= send_byte;
					tx_start_o <= 1'b1;
				end
				send_byte:
				begin
					if (tx_done_i)
					begin
						byte_timer <= '0;
						packet_timer <= '0;
						state <= rest_transmission;
					end
				end
				rest_transmission:
				begin
					if (!packet_sent)
					begin
						if (byte_gap_done)
						begin
							byte_index <= byte_index + 1'b1;
							state <= rest_byte;
						end
						else
							byte_timer <= byte_timer + 1'b1;
					end
					else if (!data_left)
						state <= idle;
					else if (packet_gap_done)
					begin
						state <= wait_for_clearance;
						advance_o <= 1'b1;
					end
					else
						packet_timer <= packet_timer + 1'b1;
				end
				default:
				begin
					state <= idle;
				end
			endcase
		end
	end

	// Single packet stage
	always_ff @(posedge clock)
	begin
		if (state == load_buffer)
			buffer <= packet_t'(frame_i);
	end

	// Index zero picks the top byte
	assign tx_byte_o = buffer[LAST_BYTE - byte_index];
	assign busy_o = (state != idle);

endmodule

`default_nettype wire

// ==== logic/stream_fifo_bank.sv ====
// Eight per-channel frame queues with write-when-not-full and a selected read port
`timescale 1ns/1ps
`default_nettype none

module stream_fifo_bank (
	input logic clock,
	input logic reset,
	input link_frame_pkg::channel_mask_t frame_ready_i,
	input link_frame_pkg::payload_t payload_i [link_frame_pkg::N_CHANNELS],
	input logic pop_i,
	input link_frame_pkg::channel_id_t select_i,
	output link_frame_pkg::frame_t frame_o,
	output link_frame_pkg::channel_mask_t empty_o
);
	import link_frame_pkg::*;

	frame_t head [N_CHANNELS];
	channel_mask_t full;

	for (genvar ch = 0; ch < N_CHANNELS; ch++)
	begin : g_queue
		frame_t mem [FIFO_DEPTH];
		frame_t stamped;
		fifo_ptr_t wr_ptr;
		fifo_ptr_t rd_ptr;
		fifo_count_t count;
		logic push;
		logic pull;

		assign full[ch] = (count == fifo_count_t'(FIFO_DEPTH));
		assign empty_o[ch] = (count == '0);

		// A frame arriving on a full queue is lost
		assign push = frame_ready_i[ch] & ~full[ch];
		assign pull = pop_i & (select_i == channel_id_t'(ch)) & ~empty_o[ch];

		// Channel number goes into both id bytes
		assign stamped = '{
			trailer_id: 8'(ch),
			pad: 2'b00,
			payload: payload_i[ch],
			header_id: 8'(ch)
		};

		always_ff @(posedge clock)
		begin
			if (push)
				mem[wr_ptr] <= stamped;
		end

		always_ff @(posedge clock or posedge reset)
		begin
			if (reset)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				count <= '0;
			end
			else
			begin
				if (push)
					wr_ptr <= wr_ptr + 1'b1;
				if (pull)
					rd_ptr <= rd_ptr + 1'b1;
				case ({push, pull})
					2'b10: count <= count + 1'b1;
					2'b01: count <= count - 1'b1;
					default: count <= count;
				endcase
			end
		end

		assign head[ch] = mem[rd_ptr];
	end

	// Popped frame is valid the cycle after the pop
	always_ff @(posedge clock)
	begin
		if (pop_i)
			frame_o <= head[select_i];
	end

endmodule

`default_nettype wire

// ==== logic/stream_switch.sv ====
// Round-robin channel selection over requested, non-empty queues
`timescale 1ns/1ps
`default_nettype none

module stream_switch (
	input logic clock,
	input logic reset,
	input logic advance_i,
	input link_frame_pkg::channel_mask_t mask_i,
	input link_frame_pkg::channel_mask_t empty_i,
	output link_frame_pkg::channel_id_t select_o,
	output logic select_ready_o
);
	import link_frame_pkg::*;

	channel_mask_t eligible;
	channel_id_t candidate;
	channel_id_t next_select;
	logic found;
	logic pending;

	assign eligible = mask_i & ~empty_i;

	// Rotating priority starting just after the current channel
	// Walk offsets downward so the nearest eligible channel wins
	always_comb
	begin
		next_select = select_o;
		found = 1'b0;
		candidate = select_o;
		for (int offset = N_CHANNELS; offset >= 1; offset--)
		begin
			candidate = select_o + channel_id_t'(offset);
			if (eligible[candidate])
			begin
				next_select = candidate;
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			// First search then begins at channel zero
			select_o <= channel_id_t'(N_CHANNELS - 1);
			select_ready_o <= 1'b0;
			pending <= 1'b0;
		end
		else
		begin
			select_ready_o <= 1'b0;
			if (advance_i | pending)
			begin
				if (found)
				begin
					select_o <= next_select;
					select_ready_o <= 1'b1;
					pending <= 1'b0;
				end
				else
				begin
					// Keep looking until a requested queue fills
					pending <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/uart_timing_pkg.sv ====
// UART timing configuration struct, bit counting and spacing constants
`default_nettype none

package uart_timing_pkg;

	// Clock cycle counts for bit length and byte spacing
	typedef logic [9:0] cycle_count_t;

	typedef struct packed {
		cycle_count_t cycles_per_bit;
		cycle_count_t byte_gap;
	} uart_cfg_t;

	// Bit position within one 8N1 character
	typedef logic [3:0] bit_count_t;

	localparam bit_count_t STOP_BIT = 4'd9;

	// Idle cycles between packets
	localparam int PACKET_GAP = 64;

	typedef logic [$clog2(PACKET_GAP + 1)-1:0] packet_gap_count_t;

endpackage

`default_nettype wire

// ==== logic/uart_tx.sv ====
// 8N1 UART transmitter with a programmable bit length in clock cycles
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input logic clock,
	input logic reset,
	input logic start_i,
	input logic [7:0] data_i,
	input uart_timing_pkg::cycle_count_t cycles_per_bit_i,
	output logic txd_o,
	output logic tx_done_o
);
	import uart_timing_pkg::*;

	logic busy;
	logic bit_end;
	logic [8:0] shift_reg;
	cycle_count_t bit_timer;
	bit_count_t bit_count;

	assign bit_end = (bit_timer == cycles_per_bit_i - cycle_count_t'(1));

	// Data bits then the stop bit shift out from the bottom
	always_ff @(posedge clock)
	begin
		if (start_i & ~busy)
			shift_reg <= {1'b1, data_i};
		else if (busy & bit_end)
			shift_reg <= {1'b1, shift_reg[8:1]};
	end

	always_ff @(posedge clock or posedge reset)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			txd_o <= 1'b1;
			tx_done_o <= 1'b0;
			bit_timer <= '0;
			bit_count <= '0;
		end
		else
		begin
			tx_done_o <= 1'b0;
			if (!busy)
			begin
				// Start bit begins right away
				if (start_i)
				begin
					busy <= 1'b1;
					txd_o <= 1'b0;
					bit_timer <= '0;
					bit_count <= '0;
				end
			end
			else if (!bit_end)
				bit_timer <= bit_timer + 1'b1;
			else if (bit_count == STOP_BIT)
			begin
				busy <= 1'b0;
				txd_o <= 1'b1;
				tx_done_o <= 1'b1;
			end
			else
			begin
				bit_timer <= '0;
				bit_count <= bit_count + 1'b1;
				txd_o <= shift_reg[0];
			end
		end
	end

endmodule

`default_nettype wire

// ==== verification/bt_stream_link_golden.txt ====
// Each row: control {kind, channel, mask[7:0], enable, cycles[11:0]} then a data word
// Kinds: 1 levels, 2 frame (payload), 3 expected packet (first byte on top), 4 idle, 5 quiet, 0 end
10ff0000 0
25000000 0123456789abcdef0123456789ab
21000000 3fedcba9876543210fedcba98765
26000000 2a5a5a5a5a5a5a5a5a5a5a5a5a5a
50000028 0
10ff1000 0
31000000 013fedcba9876543210fedcba9876501
35000000 050123456789abcdef0123456789ab05
36000000 062a5a5a5a5a5a5a5a5a5a5a5a5a5a06
40000000 0
// Rotation continues after channel 6
10ff0000 0
27000000 3fffffffffffffffffffffffffff
22000000 1234123412341234123412341234
10ff1000 0
37000000 073fffffffffffffffffffffffffff07
32000000 02123412341234123412341234123402
40000000 0
23000000 1c3c5c7c9cbcdcfc1e3e5e7e9ebe
33000000 031c3c5c7c9cbcdcfc1e3e5e7e9ebe03
40000000 0
// Channel 6 held back by the mask
100f1000 0
22000000 2222222222222222222222222222
26000000 0666666666666666666666666666
32000000 02222222222222222222222222222202
40000000 0
5000001e 0
10ff1000 0
36000000 06066666666666666666666666666606
40000000 0
// Fifth frame into a full queue is lost
10ff0000 0
24000000 0404040404040404040404040401
24000000 0404040404040404040404040402
24000000 0404040404040404040404040403
24000000 0404040404040404040404040404
24000000 0404040404040404040404040405
10ff1000 0
34000000 04040404040404040404040404040104
34000000 04040404040404040404040404040204
34000000 04040404040404040404040404040304
34000000 04040404040404040404040404040404
40000000 0
00000000 0

// ==== verification/bt_stream_link_tb.sv ====
// Testbench for the datastream link with golden-file steps, serial decoding and a watchdog
`timescale 1ns/1ps
`default_nettype none

module bt_stream_link_tb;
	import link_frame_pkg::*;
	import uart_timing_pkg::*;

	localparam int CYCLES_PER_BIT = 4;
	localparam int BYTE_GAP = 3;
	localparam int GOLDEN_STEPS = 42;
	localparam int PACKET_CYCLES = PACKET_BYTES * 13 * CYCLES_PER_BIT + PACKET_GAP + 200;

	logic clock;
	logic reset;
	channel_mask_t frame_ready_i;
	payload_t payload_i [N_CHANNELS];
	channel_mask_t stream_mask_i;
	logic send_enable_i;
	uart_cfg_t uart_cfg_i;
	logic txd_o;
	logic busy_o;

	// Two words per step with control before data
	logic [127:0] golden [2 * GOLDEN_STEPS];
	logic [127:0] packets [$];
	int value_errors;
	int protocol_errors;
	int timing_errors;
	int watchdog_cycles;

	bt_stream_link DUT (
		.clock(clock),
		.reset(reset),
		.frame_ready_i(frame_ready_i),
		.payload_i(payload_i),
		.stream_mask_i(stream_mask_i),
		.send_enable_i(send_enable_i),
		.uart_cfg_i(uart_cfg_i),
		.txd_o(txd_o),
		.busy_o(busy_o)
	);

	always #50 clock = ~clock;

	task automatic apply_levels(input channel_mask_t mask, input logic enable);
		@(posedge clock);
		stream_mask_i <= mask;
		send_enable_i <= enable;
	endtask

	task automatic pulse_frame(input int ch, input payload_t data);
		int idle;
		idle = $urandom % 4;
		@(posedge clock);
		frame_ready_i <= channel_mask_t'(1) << ch;
		payload_i[ch] <= data;
		@(posedge clock);
		frame_ready_i <= '0;
		repeat (idle) @(posedge clock);
	endtask

	task automatic expect_packet(input logic [127:0] expected);
		logic [127:0] received;
		while (packets.size() == 0)
			@(negedge clock);
		received = packets.pop_front();
		assert (received == expected)
		else
		begin
			value_errors++;
			$display("Error at %0t: txd_o packet expected %h, got %h", $time, expected, received);
		end
	endtask

	task automatic wait_idle();
		while (busy_o !== 1'b0)
			@(negedge clock);
		assert (packets.size() == 0)
		else
		begin
			protocol_errors++;
			$display("Link went idle with %0d unexpected packets on the line", packets.size());
		end
	endtask

	// Nothing may leave the link for a while
	task automatic hold_quiet(input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			assert (busy_o === 1'b0)
			else
			begin
				value_errors++;
				$display("Error at %0t: busy_o expected 0, got %b", $time, busy_o);
			end
			assert (txd_o === 1'b1)
			else
			begin
				value_errors++;
				$display("Error at %0t: txd_o expected 1, got %b", $time, txd_o);
			end
		end
	endtask

	task automatic run_step(input logic [127:0] control, input logic [127:0] data);
		case (control[31:28])
			4'h1: apply_levels(control[23:16], control[12]);
			4'h2: pulse_frame(int'(control[26:24]), data[PAYLOAD_BITS-1:0]);
			4'h3: expect_packet(data);
			4'h4: wait_idle();
			4'h5: hold_quiet(int'(control[11:0]));
			default:
			begin
				protocol_errors++;
				$display("Golden file holds an unknown step kind %h", control[31:28]);
			end
		endcase
	endtask

	initial
	begin : main_sequence
		int step;
		int packet_count;
		clock = 1'b0;
		reset = 1'b1;
		frame_ready_i = '0;
		for (int ch = 0; ch < N_CHANNELS; ch++)
			payload_i[ch] = '0;
		stream_mask_i = '0;
		send_enable_i = 1'b0;
		uart_cfg_i = '{
			cycles_per_bit: cycle_count_t'(CYCLES_PER_BIT),
			byte_gap: cycle_count_t'(BYTE_GAP)
		};
		value_errors = 0;
		protocol_errors = 0;
		timing_errors = 0;
		void'($urandom(32'hc933be98));
		$readmemh("verification/bt_stream_link_golden.txt", golden);
		packet_count = 0;
		for (step = 0; step < GOLDEN_STEPS; step++)
		begin
			if (golden[2 * step][31:28] == 4'h3)
				packet_count++;
		end
		watchdog_cycles = packet_count * PACKET_CYCLES;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		step = 0;
		while (step < GOLDEN_STEPS && golden[2 * step][31:28] != 4'h0)
		begin
			run_step(golden[2 * step], golden[2 * step + 1]);
			step++;
		end
		$display("Errors: %0d value, %0d protocol, %0d timing",
			value_errors, protocol_errors, timing_errors);
		if (value_errors + protocol_errors + timing_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// Samples txd_o at mid-bit and gathers sixteen-byte packets
	initial
	begin : serial_decoder
		logic [7:0] rx_byte;
		logic [127:0] packet_acc;
		int byte_pos;
		int idle_run;
		int required;
		logic have_prev;
		logic went_idle;
		byte_pos = 0;
		have_prev = 1'b0;
		packet_acc = '0;
		forever
		begin
			idle_run = 0;
			went_idle = 1'b0;
			@(negedge clock);
			while (txd_o !== 1'b0)
			begin
				idle_run++;
				if (busy_o !== 1'b1)
					went_idle = 1'b1;
				@(negedge clock);
			end
			// Spacing only counts while the link stayed busy
			if (have_prev && !went_idle)
			begin
				required = (byte_pos == 0) ? PACKET_GAP : BYTE_GAP;
				assert (idle_run >= required)
				else
				begin
					timing_errors++;
					$display("Line was idle only %0d cycles before byte %0d, at least %0d needed",
						idle_run, byte_pos, required);
				end
			end
			repeat (CYCLES_PER_BIT / 2) @(negedge clock);
			assert (txd_o === 1'b0)
			else
			begin
				protocol_errors++;
				$display("Error at %0t: txd_o start bit expected 0, got %b", $time, txd_o);
			end
			for (int b = 0; b < 8; b++)
			begin
				repeat (CYCLES_PER_BIT) @(negedge clock);
				rx_byte[b] = txd_o;
			end
			repeat (CYCLES_PER_BIT) @(negedge clock);
			assert (txd_o === 1'b1)
			else
			begin
				protocol_errors++;
				$display("Error at %0t: txd_o stop bit expected 1, got %b", $time, txd_o);
			end
			packet_acc = {packet_acc[119:0], rx_byte};
			have_prev = 1'b1;
			byte_pos++;
			if (byte_pos == PACKET_BYTES)
			begin
				packets.push_back(packet_acc);
				byte_pos = 0;
			end
		end
	end

	initial
	begin : watchdog
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("Timeout: the link did not finish within %0d cycles", watchdog_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/link_frame_pkg.sv
logic/uart_timing_pkg.sv
logic/stream_fifo_bank.sv
logic/stream_switch.sv
logic/packet_sequencer.sv
logic/uart_tx.sv
logic/bt_stream_link.sv
verification/bt_stream_link_tb.sv
